/* Makefile */
SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: run

obj_dir/Veth_echo_tb: $(SRCS) eth_echo_top.f
	verilator --binary --timing --assert -Wno-fatal --top-module eth_echo_tb -f eth_echo_top.f

run: obj_dir/Veth_echo_tb
	./obj_dir/Veth_echo_tb | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* eth_echo_checker.sv */
`timescale 1ns/1ps

module eth_echo_checker #(
    parameter int IFG_CYCLES = 24              // minimum tx gap.
) (
    input logic                  i_clk,
    input logic                  i_reset,
    input logic                  i_tx_valid,   // fifo head valid.
    input logic                  i_tx_ready,   // tx pop.
    input eth_pkg::stream_beat_t i_tx_beat,
    input eth_pkg::rgmii_nib_t   i_rgmii_tx,
    input logic                  i_overflow
);

    int   low_cnt;                             // ctl-low cycles, saturates.
    logic seen_frame;                          // a tx frame went out since reset.

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            low_cnt    <= 0;
            seen_frame <= 1'b0;
        end else if (i_rgmii_tx.ctl) begin
            low_cnt    <= 0;
            seen_frame <= 1'b1;
        end else if (low_cnt < IFG_CYCLES) begin
            low_cnt <= low_cnt + 1;
        end
    end

    a_valid_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tx_valid && !i_tx_ready |=> i_tx_valid && $stable(i_tx_beat))
        else $error("tx stream valid dropped or beat changed before transfer");

    a_reset_idle: assert property (@(posedge i_clk) $past(i_reset) |-> !i_rgmii_tx.ctl)
        else $error("tx ctl high while in reset");

    // gap measured at the rising ctl of the next frame.
    a_ifg: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_rgmii_tx.ctl) && seen_frame |-> low_cnt >= IFG_CYCLES)
        else $error("tx inter-frame gap shorter than %0d cycles", IFG_CYCLES);

    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset) !i_overflow)
        else $error("rx fifo overflow flag set");

endmodule

bind eth_echo_top eth_echo_checker #(
    .IFG_CYCLES (IFG_CYCLES)
) chk0 (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_tx_valid (tx_valid),
    .i_tx_ready (tx_ready),
    .i_tx_beat  (tx_beat),
    .i_rgmii_tx (o_rgmii_tx),
    .i_overflow (o_rx_overflow)
);

/* eth_echo_tb.sv */
`timescale 1ns/1ps

module eth_echo_tb;

    localparam int IFG_CYCLES = 24;
    localparam int HEAD_NIBS  = eth_pkg::PREAMBLE_LEN + 1;  // preamble plus sfd.
    localparam int FRAME_LEN  = 20;                         // payload bytes per frame.
    localparam int BAD_NIBS   = 20;                         // junk after a bad preamble.

    logic                  clk;
    logic                  reset;
    eth_pkg::rgmii_nib_t   rgmii_rx;
    eth_pkg::rgmii_nib_t   rgmii_tx;
    logic                  rx_overflow;

    integer                seed = 36578;
    int                    errors = 0;
    int                    checks = 0;
    int                    frames_seen = 0;     // echoed frames closed by the monitor.
    int                    timeout_cycles;
    logic [7:0]            frame_bytes[$];      // next frame to drive.
    eth_pkg::stream_beat_t sent_q[$];           // expected echo beats.
    eth_pkg::stream_beat_t mon_beats[$];        // decoded echo beats.
    eth_pkg::rgmii_nib_t   mon_head[$];         // first HEAD_NIBS nibbles of each frame.
    int                    mon_gap[$];          // ctl-low cycles before each frame.

    tb_clock_gen #(.RESET_CYCLES(16)) clk0 (.o_clk(clk), .o_reset(reset));

    eth_echo_top #(
        .FIFO_DEPTH (64),
        .IFG_CYCLES (IFG_CYCLES)
    ) dut0 (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_rgmii_rx    (rgmii_rx),
        .o_rgmii_tx    (rgmii_tx),
        .o_rx_overflow (rx_overflow)
    );

    function automatic eth_pkg::rgmii_nib_t make_nib(input logic ctl, input logic [3:0] d);
        eth_pkg::rgmii_nib_t n;
        n.ctl = ctl;
        n.d   = d;
        return n;
    endfunction

    function automatic int cycles_for(input int nibs);
        return 2 * (nibs + 40);                // margin for fifo and tx latency.
    endfunction

    task automatic check_beat(input string name, input eth_pkg::stream_beat_t exp,
                              input eth_pkg::stream_beat_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected data %h last %b, actual data %h last %b",
                     name, exp.data, exp.last, act.data, act.last);
        end
    endtask

    task automatic check_nib(input string name, input eth_pkg::rgmii_nib_t exp,
                             input eth_pkg::rgmii_nib_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected ctl %b d %h, actual ctl %b d %h",
                     name, exp.ctl, exp.d, act.ctl, act.d);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_gap(input string name, input int min_len, input int act);
        checks++;
        if (act < min_len) begin
            errors++;
            $display("** Error %s: expected at least %0d, actual %0d", name, min_len, act);
        end
    endtask

    task automatic drive_nib(input logic ctl, input logic [3:0] d);
        @(negedge clk);
        rgmii_rx = make_nib(ctl, d);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_nib(1'b0, 4'h0);
    endtask

    // random payload with last on the final expected beat.
    task automatic build_frame(input int n_bytes);
        eth_pkg::stream_beat_t beat;
        frame_bytes.delete();
        for (int i = 0; i < n_bytes; i++) begin
            beat.data = 8'($random(seed));
            beat.last = (i == n_bytes - 1);
            frame_bytes.push_back(beat.data);
            sent_q.push_back(beat);
        end
    endtask

    task automatic send_frame();
        repeat (eth_pkg::PREAMBLE_LEN) drive_nib(1'b1, eth_pkg::PREAMBLE_NIB);
        drive_nib(1'b1, eth_pkg::SFD_NIB);
        foreach (frame_bytes[i]) begin
            drive_nib(1'b1, frame_bytes[i][3:0]);   // low nibble first.
            drive_nib(1'b1, frame_bytes[i][7:4]);
        end
        drive_nib(1'b0, 4'h0);
    endtask

    // one echoed frame against the head nibbles and the next expected beats.
    task automatic check_frame(input string name);
        eth_pkg::stream_beat_t exp;
        for (int i = 0; i < HEAD_NIBS; i++) begin
            if (mon_head.size() == 0) begin
                errors++;
                $display("%s: echoed frame ended before its start delimiter", name);
                return;
            end
            check_nib(name, make_nib(1'b1, (i < eth_pkg::PREAMBLE_LEN) ?
                      eth_pkg::PREAMBLE_NIB : eth_pkg::SFD_NIB), mon_head.pop_front());
        end
        do begin
            exp = sent_q.pop_front();
            if (mon_beats.size() == 0) begin
                errors++;
                $display("%s: echoed frame is shorter than the sent frame", name);
                return;
            end
            check_beat(name, exp, mon_beats.pop_front());
        end while (!exp.last && sent_q.size() > 0);
    endtask

    task automatic test_reset_state();
        do begin
            @(negedge clk);
            check_flag("reset_state ctl", 1'b0, rgmii_tx.ctl);
            check_flag("reset_state overflow", 1'b0, rx_overflow);
        end while (reset);
        repeat (4) begin
            @(negedge clk);
            check_flag("reset_state idle ctl", 1'b0, rgmii_tx.ctl);
            check_flag("reset_state idle overflow", 1'b0, rx_overflow);
        end
    endtask

    task automatic test_single_echo();
        int base;
        base = frames_seen;
        build_frame(FRAME_LEN);
        send_frame();
        wait (frames_seen >= base + 1);
        check_frame("single_echo");
    endtask

    task automatic test_back_to_back();
        int base;
        base = frames_seen;
        mon_gap.delete();                      // first gap follows the previous frame.
        repeat (3) begin
            build_frame(FRAME_LEN);
            send_frame();
            idle_cycles(12);
        end
        wait (frames_seen >= base + 3);
        repeat (3) check_frame("back_to_back");
        check_count("back_to_back gap count", 3, mon_gap.size());
        foreach (mon_gap[i]) check_gap("back_to_back gap", IFG_CYCLES, mon_gap[i]);
    endtask

    task automatic test_bad_preamble();
        int base;
        base = frames_seen;
        repeat (eth_pkg::PREAMBLE_LEN) drive_nib(1'b1, eth_pkg::PREAMBLE_NIB);
        repeat (BAD_NIBS) drive_nib(1'b1, 4'($random(seed)) & 4'h7);  // never a d.
        idle_cycles(12);
        check_count("bad_preamble stray nibbles", 0, mon_head.size());
        build_frame(FRAME_LEN);
        send_frame();
        wait (frames_seen >= base + 1);
        check_frame("bad_preamble");
        idle_cycles(2 * IFG_CYCLES);           // a stray frame would have started.
        check_count("bad_preamble frames", base + 1, frames_seen);
    endtask

    // decodes tx nibbles into head nibbles, beats and gaps.
    initial begin : tx_monitor
        int                    nib_idx;
        int                    low_cnt;
        logic [3:0]            lo;
        eth_pkg::stream_beat_t beat;
        eth_pkg::stream_beat_t frame_q[$];
        nib_idx = -1;                          // between frames.
        low_cnt = -1;                          // no frame ended yet.
        forever begin
            @(negedge clk);
            if (rgmii_tx.ctl) begin
                if (nib_idx < 0) begin
                    if (low_cnt >= 0) mon_gap.push_back(low_cnt);
                    nib_idx = 0;
                    frame_q.delete();
                end
                if (nib_idx < HEAD_NIBS) begin
                    mon_head.push_back(rgmii_tx);
                end else if ((nib_idx - HEAD_NIBS) % 2 == 0) begin
                    lo = rgmii_tx.d;
                end else begin
                    beat.data = {rgmii_tx.d, lo};
                    beat.last = 1'b0;
                    frame_q.push_back(beat);
                end
                nib_idx++;
            end else begin
                if (nib_idx >= 0) begin
                    foreach (frame_q[i]) begin
                        beat      = frame_q[i];
                        beat.last = (i == frame_q.size() - 1);  // ctl fell after it.
                        mon_beats.push_back(beat);
                    end
                    frames_seen++;
                    nib_idx = -1;
                    low_cnt = 0;
                end
                if (low_cnt >= 0) low_cnt++;
            end
        end
    end

    initial begin : watchdog
        timeout_cycles = 1000 + cycles_for(HEAD_NIBS + 2 * FRAME_LEN)
                       + 3 * cycles_for(HEAD_NIBS + 2 * FRAME_LEN)
                       + cycles_for(eth_pkg::PREAMBLE_LEN + BAD_NIBS)
                       + cycles_for(HEAD_NIBS + 2 * FRAME_LEN);
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the echo did not complete", timeout_cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin : run_tests
        rgmii_rx = make_nib(1'b0, 4'h0);
        test_reset_state();
        test_single_echo();
        test_back_to_back();
        test_bad_preamble();
        check_flag("rx_overflow", 1'b0, rx_overflow);
        check_count("leftover echo beats", 0, mon_beats.size());
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* eth_echo_top.f */
eth_pkg.sv
rgmii_rx.sv
frame_fifo.sv
rgmii_tx.sv
eth_echo_top.sv
tb_clock_gen.sv
eth_echo_checker.sv
eth_echo_tb.sv

/* eth_echo_top.sv */
`timescale 1ns/1ps

module eth_echo_top #(
    parameter int FIFO_DEPTH = 64,             // frame buffer entries.
    parameter int IFG_CYCLES = 24              // tx gap length.
) (
    input  logic                i_clk,
    input  logic                i_reset,
    input  eth_pkg::rgmii_nib_t i_rgmii_rx,    // from phy.
    output eth_pkg::rgmii_nib_t o_rgmii_tx,    // to phy.
    output logic                o_rx_overflow  // sticky, fifo dropped a byte.
);

    eth_pkg::stream_beat_t rx_beat;
    logic                  rx_valid;           // no ready, phy cannot stall.
    eth_pkg::stream_beat_t tx_beat;
    logic                  tx_valid;
    logic                  tx_ready;

    rgmii_rx rx0 (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_rgmii (i_rgmii_rx),
        .o_beat  (rx_beat),
        .o_valid (rx_valid)
    );

    // buffered loopback between receive and transmit.
    frame_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_beat     (rx_beat),
        .i_valid    (rx_valid),
        .o_beat     (tx_beat),
        .o_valid    (tx_valid),
        .i_ready    (tx_ready),
        .o_overflow (o_rx_overflow)
    );

    rgmii_tx #(
        .IFG_CYCLES (IFG_CYCLES)
    ) tx0 (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_beat  (tx_beat),
        .i_valid (tx_valid),
        .o_ready (tx_ready),
        .o_rgmii (o_rgmii_tx)
    );

endmodule

/* eth_pkg.sv */
// shared types and framing constants for the echo path.
package eth_pkg;

    localparam int NIB_W  = 4;               // rgmii data lanes.
    localparam int BYTE_W = 8;               // payload byte width.

    // one rgmii transfer per i_clk cycle (sdr model).
    typedef struct packed {
        logic             ctl;               // data valid.
        logic [NIB_W-1:0] d;                 // data nibble.
    } rgmii_nib_t;

    // one payload byte on the internal byte stream.
    typedef struct packed {
        logic [BYTE_W-1:0] data;             // payload byte.
        logic              last;             // final byte of frame.
    } stream_beat_t;

    // preamble is 0x55 bytes, so every nibble reads 5.
    localparam logic [NIB_W-1:0] PREAMBLE_NIB = 4'h5;

    // sfd byte 0xd5 goes out low nibble first, so 5 then d.
    localparam logic [NIB_W-1:0] SFD_NIB = 4'hd;

    // 7 preamble bytes plus the low half of the sfd.
    localparam int PREAMBLE_LEN = 15;

endpackage

/* frame_fifo.sv */
`timescale 1ns/1ps

module frame_fifo #(
    parameter int FIFO_DEPTH = 64              // entries, power of two.
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  eth_pkg::stream_beat_t i_beat,
    input  logic                  i_valid,     // write strobe.
    output eth_pkg::stream_beat_t o_beat,      // registered head.
    output logic                  o_valid,
    input  logic                  i_ready,
    output logic                  o_overflow   // sticky.
);

    localparam int AW = $clog2(FIFO_DEPTH);

    eth_pkg::stream_beat_t mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;                       // extra msb tells full from empty.
    logic [AW:0] rd_ptr;

    logic mem_empty;
    logic mem_full;
    logic out_free;                            // head register can take a new beat.
    logic mem_rd;
    logic bypass;                              // write goes straight to head.
    logic mem_wr;

    assign mem_empty = (wr_ptr == rd_ptr);
    assign mem_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign out_free  = !o_valid || i_ready;
    assign mem_rd    = out_free && !mem_empty;
    assign bypass    = out_free && mem_empty && i_valid;
    assign mem_wr    = i_valid && !bypass && (!mem_full || mem_rd);

    // pointers, head valid and overflow.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            o_valid    <= 1'b0;
            o_overflow <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_free) begin
                o_valid <= mem_rd || bypass;
            end
            if (i_valid && !bypass && mem_full && !mem_rd) begin
                o_overflow <= 1'b1;            // beat lost.
            end
        end
    end

    // storage and head data.
    always_ff @(posedge i_clk) begin
        if (mem_wr) begin
            mem[wr_ptr[AW-1:0]] <= i_beat;
        end
        if (mem_rd) begin
            o_beat <= mem[rd_ptr[AW-1:0]];
        end else if (bypass) begin
            o_beat <= i_beat;                  // empty fifo, one cycle latency.
        end
    end

endmodule

/* rgmii_rx.sv */
`timescale 1ns/1ps

module rgmii_rx (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  eth_pkg::rgmii_nib_t  i_rgmii,      // nibble from phy.
    output eth_pkg::stream_beat_t o_beat,      // assembled byte.
    output logic                 o_valid       // one-cycle strobe without stall.
);

    typedef enum logic [1:0] {
        ST_IDLE,                               // waiting for ctl and preamble.
        ST_PRE,                                // inside preamble, hunting sfd.
        ST_DATA                                // pairing payload nibbles.
    } rx_state_t;

    rx_state_t                     state;
    logic                          nib_phase;  // 1 once low nibble is captured.
    logic                          have_byte;  // held byte waits for its last mark.
    logic [eth_pkg::NIB_W-1:0]     lo_nib;     // low half of current byte.
    logic [eth_pkg::BYTE_W-1:0]    held_byte;  // completed byte, emitted later.

    // control path.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= ST_IDLE;
            nib_phase <= 1'b0;
            have_byte <= 1'b0;
            o_valid   <= 1'b0;
        end else begin
            o_valid <= 1'b0;                   // strobe by default.
            case (state)
                ST_IDLE: begin
                    if (i_rgmii.ctl && i_rgmii.d == eth_pkg::PREAMBLE_NIB) begin
                        state <= ST_PRE;       // first 5 seen.
                    end
                end
                ST_PRE: begin
                    if (!i_rgmii.ctl) begin
                        state <= ST_IDLE;      // frame without sfd is dropped.
                    end else if (i_rgmii.d == eth_pkg::SFD_NIB) begin
                        state     <= ST_DATA;
                        nib_phase <= 1'b0;
                        have_byte <= 1'b0;
                    end
                end
                ST_DATA: begin
                    if (!i_rgmii.ctl) begin
                        // end of frame drops a dangling half byte.
                        o_valid   <= have_byte;
                        have_byte <= 1'b0;
                        nib_phase <= 1'b0;
                        state     <= ST_IDLE;
                    end else if (!nib_phase) begin
                        o_valid   <= have_byte; // release held byte as next one starts.
                        have_byte <= 1'b0;
                        nib_phase <= 1'b1;
                    end else begin
                        have_byte <= 1'b1;     // byte complete.
                        nib_phase <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload path.
    always_ff @(posedge i_clk) begin
        if (state == ST_DATA) begin
            if (i_rgmii.ctl && !nib_phase) begin
                lo_nib <= i_rgmii.d;           // low nibble first.
            end
            if (i_rgmii.ctl && nib_phase) begin
                held_byte <= {i_rgmii.d, lo_nib};
            end
            if (have_byte && !(i_rgmii.ctl && nib_phase)) begin
                o_beat.data <= held_byte;
                o_beat.last <= !i_rgmii.ctl;   // final byte once ctl fell.
            end
        end
    end

endmodule

/* rgmii_tx.sv */
`timescale 1ns/1ps

module rgmii_tx #(
    parameter int IFG_CYCLES = 24              // idle cycles after each frame.
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  eth_pkg::stream_beat_t i_beat,      // fifo head.
    input  logic                  i_valid,
    output logic                  o_ready,     // pops one beat per byte.
    output eth_pkg::rgmii_nib_t   o_rgmii      // nibble to phy.
);

    localparam int CNT_MAX = (IFG_CYCLES > eth_pkg::PREAMBLE_LEN) ?
                             IFG_CYCLES : eth_pkg::PREAMBLE_LEN;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRE,                                // PREAMBLE_LEN nibbles of 5.
        ST_SFD,
        ST_LO,                                 // low nibble of byte.
        ST_HI,                                 // high nibble, beat popped.
        ST_GAP                                 // inter-frame gap.
    } tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] cnt;

    // sequencing.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_valid) begin
                        state <= ST_PRE;       // frame waiting.
                        cnt   <= '0;
                    end
                end
                ST_PRE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(eth_pkg::PREAMBLE_LEN - 1)) begin
                        state <= ST_SFD;
                    end
                end
                ST_SFD: state <= ST_LO;
                ST_LO: begin
                    if (i_valid) begin
                        state <= ST_HI;
                    end else begin
                        state <= ST_GAP;       // underrun, truncate frame.
                        cnt   <= '0;
                    end
                end
                ST_HI: begin
                    if (i_beat.last) begin
                        state <= ST_GAP;
                        cnt   <= '0;
                    end else begin
                        state <= ST_LO;
                    end
                end
                ST_GAP: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(IFG_CYCLES - 1)) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign o_ready = (state == ST_HI);         // transfer at end of high nibble.

    // line encoding from state.
    always_comb begin
        o_rgmii.ctl = 1'b0;
        o_rgmii.d   = '0;
        case (state)
            ST_PRE: begin
                o_rgmii.ctl = 1'b1;
                o_rgmii.d   = eth_pkg::PREAMBLE_NIB;
            end
            ST_SFD: begin
                o_rgmii.ctl = 1'b1;
                o_rgmii.d   = eth_pkg::SFD_NIB;
            end
            ST_LO: begin
                o_rgmii.ctl = i_valid;         // drops early on underrun.
                o_rgmii.d   = i_beat.data[3:0];
            end
            ST_HI: begin
                o_rgmii.ctl = 1'b1;
                o_rgmii.d   = i_beat.data[7:4];
            end
            default: begin
                o_rgmii.ctl = 1'b0;            // idle and gap.
                o_rgmii.d   = '0;
            end
        endcase
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16            // cycles reset is held.
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;             // 10 ns period.
    end

    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset <= 1'b0;                       // released on a falling edge.
    end

endmodule
